//--- src/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Pixels per window, one coefficient per tap.
`define CONV_TAPS 9

// Pixel and coefficient width.
`define CONV_SAMPLE_W 16

// Two operand widths plus guard bits for the tap sum.
`define CONV_ACC_W 36

// Rounding shift and saturated output width.
`define CONV_SHIFT 8
`define CONV_OUT_W 16

`endif

//--- src/conv_pkg.sv
`default_nettype none

`include "conv_cfg.svh"

package conv_pkg;

    // Signed pixel sample.
    typedef logic signed [`CONV_SAMPLE_W-1:0] sample_t;

    // Signed kernel coefficient.
    typedef logic signed [`CONV_SAMPLE_W-1:0] coef_t;

    // Running window sum.
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // Tap position inside a window, 0 to CONV_TAPS-1.
    typedef logic [$clog2(`CONV_TAPS)-1:0] tap_idx_t;

    // Rounded and saturated result.
    typedef logic signed [`CONV_OUT_W-1:0] out_t;

endpackage

`default_nettype wire

//--- src/mac_if.sv
`default_nettype none

// Paired operands from the kernel store into the MAC pipeline.
interface mac_if;
    import conv_pkg::*;

    logic    valid;   // Single-cycle strobe.
    sample_t sample;  // Pixel of this tap.
    coef_t   coef;    // Coefficient of this tap.
    logic    first;   // Tap 0 of a window.
    logic    last;    // Final tap of a window.

    modport src (
        output valid, sample, coef, first, last
    );

    modport dst (
        input  valid, sample, coef, first, last
    );

endinterface

`default_nettype wire

//--- src/kernel_store.sv
`default_nettype none

`include "conv_cfg.svh"

module kernel_store (
    input  logic                clk,
    input  logic                rst,

    input  logic                coef_valid,
    input  conv_pkg::tap_idx_t  coef_addr,
    input  conv_pkg::coef_t     coef_data,

    input  logic                pix_valid,
    input  conv_pkg::sample_t   pix_data,

    mac_if.src                  mac
);
    import conv_pkg::*;

    localparam tap_idx_t LAST_TAP = tap_idx_t'(`CONV_TAPS - 1);

    coef_t    coef_mem [`CONV_TAPS];  // One register per tap.
    tap_idx_t tap_cnt;                // Position of the next pixel.
    logic     tap_first;
    logic     tap_last;

    assign tap_first = (tap_cnt == '0);
    assign tap_last  = (tap_cnt == LAST_TAP);

    // Coefficient writes take effect at the next edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                coef_mem[i] <= '0;
            end
        end else if (coef_valid) begin
            coef_mem[coef_addr] <= coef_data;
        end
    end

    // Tap counter, wraps at the end of each window.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_cnt <= '0;
        end else if (pix_valid) begin
            tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
        end
    end

    // Pixel and its coefficient leave together one cycle after the strobe.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mac.valid  <= 1'b0;
            mac.first  <= 1'b0;
            mac.last   <= 1'b0;
            mac.sample <= '0;
            mac.coef   <= '0;
        end else begin
            mac.valid <= pix_valid;
            mac.first <= pix_valid & tap_first;  // Restarts the sum downstream.
            mac.last  <= pix_valid & tap_last;   // Closes the window.
            if (pix_valid) begin
                mac.sample <= pix_data;
                mac.coef   <= coef_mem[tap_cnt];
            end
        end
    end

    // A write outside the kernel would be silently lost.
    a_coef_addr_range: assert property (@(posedge clk) disable iff (rst)
        coef_valid |-> (coef_addr < `CONV_TAPS));

    // Framing flags ride only on valid beats of the interface.
    a_flags_with_valid: assert property (@(posedge clk) disable iff (rst)
        (mac.first || mac.last) |-> mac.valid);

endmodule

`default_nettype wire

//--- src/multiply_acc.sv
`default_nettype none

`include "conv_cfg.svh"

module multiply_acc (
    input  logic            clk,
    input  logic            rst,

    mac_if.dst              mac,

    output logic            acc_valid,
    output conv_pkg::acc_t  acc_sum
);
    import conv_pkg::*;

    typedef logic signed [2*`CONV_SAMPLE_W-1:0] prod_t;

    // Stage 1, operand register.
    logic    s1_valid;
    logic    s1_first;
    logic    s1_last;
    sample_t s1_sample;
    coef_t   s1_coef;

    // Stage 2, product register.
    logic    s2_valid;
    logic    s2_first;
    logic    s2_last;
    prod_t   s2_product;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s1_first  <= 1'b0;
            s1_last   <= 1'b0;
            s1_sample <= '0;
            s1_coef   <= '0;
        end else begin
            s1_valid <= mac.valid;
            s1_first <= mac.valid & mac.first;
            s1_last  <= mac.valid & mac.last;
            if (mac.valid) begin
                s1_sample <= mac.sample;
                s1_coef   <= mac.coef;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_valid   <= 1'b0;
            s2_first   <= 1'b0;
            s2_last    <= 1'b0;
            s2_product <= '0;
        end else begin
            s2_valid   <= s1_valid;
            s2_first   <= s1_first;
            s2_last    <= s1_last;
            s2_product <= s1_sample * s1_coef;  // Full-width signed product.
        end
    end

    // Stage 3. The first tap reloads the sum, so windows can overlap.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_valid <= 1'b0;
            acc_sum   <= '0;
        end else begin
            acc_valid <= s2_valid & s2_last;
            if (s2_valid) begin
                acc_sum <= s2_first ? acc_t'(s2_product) : acc_sum + acc_t'(s2_product);
            end
        end
    end

    a_product_correct: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (s2_product == $past(s1_sample) * $past(s1_coef)));

    // No stale window may leak out right after reset.
    a_no_valid_after_rst: assert property (@(posedge clk)
        $past(rst) |-> !acc_valid);

endmodule

`default_nettype wire

//--- src/result_emitter.sv
`default_nettype none

`include "conv_cfg.svh"

module result_emitter (
    input  logic            clk,
    input  logic            rst,

    input  logic            acc_valid,
    input  conv_pkg::acc_t  acc_sum,

    output logic            result_valid,
    output conv_pkg::out_t  result,
    output logic            result_clipped
);
    import conv_pkg::*;

    localparam out_t OUT_MAX = {1'b0, {(`CONV_OUT_W-1){1'b1}}};
    localparam out_t OUT_MIN = {1'b1, {(`CONV_OUT_W-1){1'b0}}};

    acc_t shifted;
    logic over_hi;
    logic over_lo;
    out_t clamped;

    // Arithmetic shift rounds toward negative infinity.
    assign shifted = acc_sum >>> `CONV_SHIFT;

    assign over_hi = (shifted > acc_t'(OUT_MAX));
    assign over_lo = (shifted < acc_t'(OUT_MIN));

    always_comb begin
        if (over_hi) begin
            clamped = OUT_MAX;
        end else if (over_lo) begin
            clamped = OUT_MIN;
        end else begin
            clamped = out_t'(shifted);  // Fits, drop the sign extension.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid   <= 1'b0;
            result_clipped <= 1'b0;
            result         <= '0;
        end else begin
            result_valid   <= acc_valid;
            result_clipped <= acc_valid & (over_hi | over_lo);
            if (acc_valid) begin
                result <= clamped;
            end
        end
    end

    a_clip_with_valid: assert property (@(posedge clk) disable iff (rst)
        result_clipped |-> result_valid);

endmodule

`default_nettype wire

//--- src/conv_engine.sv
`default_nettype none

module conv_engine (
    input  logic                clk,
    input  logic                rst,

    // Kernel coefficient writes.
    input  logic                coef_valid,
    input  conv_pkg::tap_idx_t  coef_addr,
    input  conv_pkg::coef_t     coef_data,

    // Pixel stream, one sample per strobe.
    input  logic                pix_valid,
    input  conv_pkg::sample_t   pix_data,

    // One strobe per completed window.
    output logic                result_valid,
    output conv_pkg::out_t      result,
    output logic                result_clipped
);
    import conv_pkg::*;

    logic acc_valid;
    acc_t acc_sum;

    mac_if u_mac_if ();

    kernel_store u_kernel_store (
        .clk        (clk),
        .rst        (rst),
        .coef_valid (coef_valid),
        .coef_addr  (coef_addr),
        .coef_data  (coef_data),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .mac        (u_mac_if.src)
    );

    multiply_acc u_multiply_acc (
        .clk       (clk),
        .rst       (rst),
        .mac       (u_mac_if.dst),
        .acc_valid (acc_valid),
        .acc_sum   (acc_sum)
    );

    result_emitter u_result_emitter (
        .clk            (clk),
        .rst            (rst),
        .acc_valid      (acc_valid),
        .acc_sum        (acc_sum),
        .result_valid   (result_valid),
        .result         (result),
        .result_clipped (result_clipped)
    );

endmodule

`default_nettype wire

//--- sim/conv_engine_tb.sv
`default_nettype none

`include "conv_cfg.svh"

module conv_engine_tb;
    import conv_pkg::*;

    logic     clk = 1'b0;
    logic     rst;
    logic     coef_valid;
    tap_idx_t coef_addr;
    coef_t    coef_data;
    logic     pix_valid;
    sample_t  pix_data;
    logic     result_valid;
    out_t     result;
    logic     result_clipped;

    int          coef_model [`CONV_TAPS];  // Kernel as the DUT should hold it.
    int          win_pix [`CONV_TAPS];     // Next window to stream.
    int          exp_val_q [$];
    bit          exp_clip_q [$];
    logic [31:0] lcg_state = 32'd69937;

    int cycle_cnt = 0;
    int last_pix_edge = 0;
    int last_result_cycle = 0;
    int windows_sent = 0;
    int results_seen = 0;
    int clipped_seen = 0;
    int mon_exp_v;
    bit mon_exp_c;

    conv_engine uut (
        .clk            (clk),
        .rst            (rst),
        .coef_valid     (coef_valid),
        .coef_addr      (coef_addr),
        .coef_data      (coef_data),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .result_valid   (result_valid),
        .result         (result),
        .result_clipped (result_clipped)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;  // Counts rising edges.

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_sample();
        logic [31:0] r;
        r = lcg_next();
        return int'($signed(r[31:16]));  // Upper bits have the longest period.
    endfunction

    // Inputs change a little after the edge that samples them.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Exact dot product, floor shift, then clamp to the output range.
    task automatic push_expected();
        longint acc;
        longint shifted;
        longint out_max;
        longint out_min;
        acc = 0;
        out_max = (longint'(1) <<< (`CONV_OUT_W - 1)) - 1;
        out_min = -(longint'(1) <<< (`CONV_OUT_W - 1));
        for (int i = 0; i < `CONV_TAPS; i++) begin
            acc += longint'(win_pix[i]) * longint'(coef_model[i]);
        end
        shifted = acc >>> `CONV_SHIFT;
        if (shifted > out_max) begin
            exp_val_q.push_back(int'(out_max));
            exp_clip_q.push_back(1'b1);
        end else if (shifted < out_min) begin
            exp_val_q.push_back(int'(out_min));
            exp_clip_q.push_back(1'b1);
        end else begin
            exp_val_q.push_back(int'(shifted));
            exp_clip_q.push_back(1'b0);
        end
    endtask

    task automatic load_coefs();
        for (int i = 0; i < `CONV_TAPS; i++) begin
            coef_valid = 1'b1;
            coef_addr  = tap_idx_t'(i);
            coef_data  = coef_t'(coef_model[i]);
            step();
        end
        coef_valid = 1'b0;
    endtask

    task automatic fill_random_window();
        for (int i = 0; i < `CONV_TAPS; i++) begin
            win_pix[i] = rand_sample();
        end
    endtask

    task automatic fill_const_window(input int value);
        for (int i = 0; i < `CONV_TAPS; i++) begin
            win_pix[i] = value;
        end
    endtask

    // Streams win_pix, with up to max_gap idle cycles after each pixel.
    task automatic stream_window(input int max_gap);
        int gap;
        push_expected();
        windows_sent++;
        for (int i = 0; i < `CONV_TAPS; i++) begin
            pix_valid = 1'b1;
            pix_data  = sample_t'(win_pix[i]);
            if (i == `CONV_TAPS - 1) begin
                last_pix_edge = cycle_cnt + 1;  // Edge that samples this pixel.
            end
            step();
            pix_valid = 1'b0;
            if (max_gap > 0) begin
                gap = int'(lcg_next() % 32'(max_gap + 1));
                repeat (gap) step();
            end
        end
    endtask

    task automatic wait_for_drain(input int limit);
        int n;
        n = 0;
        while (exp_val_q.size() != 0 && n < limit) begin
            step();
            n++;
        end
        assert (exp_val_q.size() == 0)
            else fail_run("timed out waiting for window results");
    endtask

    // Results are stable by the falling edge.
    always @(negedge clk) begin
        if (result_valid) begin
            assert (exp_val_q.size() > 0)
                else fail_run("result_valid strobed with no window outstanding");
            if (exp_val_q.size() > 0) begin
                mon_exp_v = exp_val_q.pop_front();
                mon_exp_c = exp_clip_q.pop_front();
                assert (int'(result) == mon_exp_v && result_clipped == mon_exp_c)
                    else fail_run($sformatf(
                        "mismatch at %0t: result %0d clipped %0b, expected %0d clipped %0b",
                        $time, result, result_clipped, mon_exp_v, mon_exp_c));
                results_seen++;
                last_result_cycle = cycle_cnt + 1;  // Edge that samples this result.
                if (result_clipped) begin
                    clipped_seen++;
                end
            end
        end
    end

    task automatic reset_behavior();
        rst = 1'b1;
        for (int i = 0; i < 16; i++) begin
            step();
            assert (!result_valid) else fail_run("result_valid high during reset");
        end
        rst = 1'b0;
        for (int i = 0; i < 20; i++) begin
            step();
            assert (!result_valid) else fail_run("result_valid high after reset with no input");
        end
        fill_random_window();  // Cleared kernel gives zero.
        stream_window(0);
        wait_for_drain(40);
    endtask

    task automatic single_window_latency();
        for (int i = 0; i < `CONV_TAPS; i++) begin
            coef_model[i] = i + 1;
            win_pix[i]    = 64 * (i + 1);
        end
        load_coefs();
        stream_window(0);
        wait_for_drain(40);
        assert (last_result_cycle - last_pix_edge == 5)
            else fail_run($sformatf("mismatch at %0t: latency %0d cycles, expected 5",
                                    $time, last_result_cycle - last_pix_edge));
    endtask

    task automatic back_to_back_windows();
        for (int w = 0; w < 20; w++) begin
            fill_random_window();
            stream_window(0);
        end
        wait_for_drain(100);
    endtask

    task automatic gapped_windows();
        for (int w = 0; w < 10; w++) begin
            fill_random_window();
            stream_window(3);
        end
        wait_for_drain(100);
    endtask

    task automatic saturation_windows();
        int clip_before;
        clip_before = clipped_seen;
        for (int i = 0; i < `CONV_TAPS; i++) begin
            coef_model[i] = 32767;
        end
        load_coefs();
        fill_const_window(32767);   // Positive clamp.
        stream_window(0);
        fill_const_window(-32768);  // Negative clamp.
        stream_window(0);
        for (int i = 0; i < `CONV_TAPS; i++) begin
            coef_model[i] = -32768;
        end
        load_coefs();
        fill_const_window(-32768);  // Both operands at minimum, positive clamp.
        stream_window(0);
        fill_const_window(1);       // Stays in range.
        stream_window(1);
        wait_for_drain(60);
        assert (clipped_seen - clip_before == 3)
            else fail_run("saturating windows did not each raise result_clipped once");
    endtask

    task automatic coefficient_reload();
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                coef_model[i] = rand_sample();
            end
            load_coefs();  // Earlier windows already hold their coefficients.
            for (int w = 0; w < 4; w++) begin
                fill_random_window();
                stream_window(1);
            end
        end
        wait_for_drain(100);
    endtask

    initial begin
        rst        = 1'b1;
        coef_valid = 1'b0;
        coef_addr  = '0;
        coef_data  = '0;
        pix_valid  = 1'b0;
        pix_data   = '0;
        for (int i = 0; i < `CONV_TAPS; i++) begin
            coef_model[i] = 0;
        end
        reset_behavior();
        single_window_latency();
        back_to_back_windows();
        gapped_windows();
        saturation_windows();
        coefficient_reload();
        repeat (10) step();
        if (exp_val_q.size() == 0 && results_seen == windows_sent) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("result count does not match the number of windows sent");
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/conv_pkg.sv
src/mac_if.sv
src/kernel_store.sv
src/multiply_acc.sv
src/result_emitter.sv
src/conv_engine.sv
sim/conv_engine_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the convolution engine testbench with Verilator.
# The result is taken from the simulation log.

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module conv_engine_tb -o conv_sim > build.log 2>&1 \
    && ./obj_dir/conv_sim > sim.log 2>&1

grep -q "TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
